// File: hw/chip8_isa_pkg.sv
// ISA definitions for the CHIP-8 core, imported by every datapath and control block
package chip8_isa_pkg;

	// Register contents and immediate bytes
	typedef logic [7:0] byte_t;

	// Program and data memory address
	typedef logic [11:0] addr_t;

	// Raw instruction word as fetched
	typedef logic [15:0] instr_t;

	// V register index, V0 to VF
	typedef logic [3:0] reg_idx_t;

	// ALU functions used by 7xkk and the 8xyk group
	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_OR,
		ALU_AND,
		ALU_XOR,
		ALU_ADD,
		ALU_SUB,
		ALU_SUBN,
		ALU_SHR,
		ALU_SHL
	} alu_op_e;

	// Programs are loaded above the interpreter area
	localparam addr_t PROG_START = 12'h200;

	// Each hex font glyph is five rows tall
	localparam addr_t FONT_STRIDE = 12'd5;

	// VF doubles as carry, not-borrow and shift-out flag
	localparam reg_idx_t FLAG_REG = 4'hF;

endpackage

// File: hw/chip8_ctrl_pkg.sv
// Microarchitecture encodings shared by the sequencer and the PC/stack block
package chip8_ctrl_pkg;

	// Sequencer phases of one instruction
	typedef enum logic [1:0] {
		SEQ_FETCH,
		SEQ_READ,
		SEQ_EXEC,
		SEQ_STORE
	} seq_state_e;

	// PC update selector
	typedef enum logic [2:0] {
		PC_HOLD,
		PC_NEXT,
		PC_SKIP,
		PC_JUMP,
		PC_RETURN
	} pc_src_e;

	// Return stack action, applied on the same edge as the PC update
	typedef enum logic [1:0] {
		STACK_HOLD,
		STACK_PUSH,
		STACK_POP
	} stack_op_e;

endpackage

// File: hw/chip8_reg_if.sv
// Register file access bundle between the sequencer and the V/I register file
`timescale 1ns/1ns

interface chip8_reg_if
	import chip8_isa_pkg::*;
();

	// Read side, combinational in the register file
	reg_idx_t rd_idx1;
	reg_idx_t rd_idx2;
	byte_t    rd_data1;
	byte_t    rd_data2;

	// Write port 1 carries the result, port 2 the VF flag
	logic     wr_en1;
	reg_idx_t wr_idx1;
	byte_t    wr_data1;
	logic     wr_en2;
	reg_idx_t wr_idx2;
	byte_t    wr_data2;

	// Index register
	logic     i_we;
	addr_t    i_wdata;
	addr_t    i_data;

	modport sequencer (
		output rd_idx1, rd_idx2,
		output wr_en1, wr_idx1, wr_data1,
		output wr_en2, wr_idx2, wr_data2,
		output i_we, i_wdata,
		input  rd_data1, rd_data2, i_data
	);

	modport regfile (
		input  rd_idx1, rd_idx2,
		input  wr_en1, wr_idx1, wr_data1,
		input  wr_en2, wr_idx2, wr_data2,
		input  i_we, i_wdata,
		output rd_data1, rd_data2, i_data
	);

endinterface

// File: hw/chip8_alu.sv
// Combinational 8-bit ALU of the CHIP-8 core, result plus VF flag
`timescale 1ns/1ns

module chip8_alu
	import chip8_isa_pkg::*;
(
	input  byte_t   a,
	input  byte_t   b,
	input  alu_op_e op,
	output byte_t   result,
	output logic    flag
);

	logic [8:0] sum;

	// Carry out of bit 7
	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		result = b;
		flag   = 1'b0;
		case (op)
			// Pass forwards b, used for loads
			ALU_PASS: result = b;
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			ALU_XOR:  result = a ^ b;
			ALU_ADD: begin
				result = sum[7:0];
				flag   = sum[8];
			end
			// Not-borrow, equal operands count as no borrow
			ALU_SUB: begin
				result = a - b;
				flag   = (a >= b);
			end
			ALU_SUBN: begin
				result = b - a;
				flag   = (b >= a);
			end
			// Shifts act on a and flag the bit shifted out
			ALU_SHR: begin
				result = {1'b0, a[7:1]};
				flag   = a[0];
			end
			ALU_SHL: begin
				result = {a[6:0], 1'b0};
				flag   = a[7];
			end
			default: ;
		endcase
	end

endmodule

// File: hw/chip8_regfile.sv
// V0..VF and I register storage of the CHIP-8 core, accessed through the register interface
`timescale 1ns/1ns

module chip8_regfile
	import chip8_isa_pkg::*;
(
	input logic          cpu_clk,
	input logic          rst_n,
	chip8_reg_if.regfile regs
);

	localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

	byte_t v_reg [NUM_REGS];
	addr_t i_reg;

	// Combinational reads
	assign regs.rd_data1 = v_reg[regs.rd_idx1];
	assign regs.rd_data2 = v_reg[regs.rd_idx2];
	assign regs.i_data   = i_reg;

	// Port 2 is written last, so the flag wins on a VF collision
	always_ff @(posedge cpu_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				v_reg[i] <= '0;
			i_reg <= '0;
		end else begin
			if (regs.wr_en1)
				v_reg[regs.wr_idx1] <= regs.wr_data1;
			if (regs.wr_en2)
				v_reg[regs.wr_idx2] <= regs.wr_data2;
			if (regs.i_we)
				i_reg <= regs.i_wdata;
		end
	end

endmodule

// File: hw/chip8_pc_stack.sv
// Program counter and return-address stack of the CHIP-8 core, driven by the sequencer
`timescale 1ns/1ns

module chip8_pc_stack
	import chip8_isa_pkg::*;
	import chip8_ctrl_pkg::*;
#(
	parameter int STACK_DEPTH = 16
) (
	input  logic      cpu_clk,
	input  logic      rst_n,
	input  pc_src_e   pc_src,
	input  addr_t     jump_addr,
	input  stack_op_e stack_op,
	output addr_t     pc
);

	localparam int SP_W  = $clog2(STACK_DEPTH + 1);
	localparam int IDX_W = $clog2(STACK_DEPTH);

	// sp counts filled entries, top of stack is sp-1
	logic [SP_W-1:0]  sp;
	logic [IDX_W-1:0] top_idx;
	addr_t            stack_mem [STACK_DEPTH];
	addr_t            ret_addr, pc_d;
	logic             full, empty;

	assign full     = (sp == SP_W'(STACK_DEPTH));
	assign empty    = (sp == '0);
	assign top_idx  = IDX_W'(sp - 1'b1);
	// Pop on an empty stack lands back at the program start
	assign ret_addr = empty ? PROG_START : stack_mem[top_idx];

	always_comb begin
		case (pc_src)
			PC_NEXT:   pc_d = pc + 12'd2;
			PC_SKIP:   pc_d = pc + 12'd4;
			PC_JUMP:   pc_d = jump_addr;
			PC_RETURN: pc_d = ret_addr;
			default:   pc_d = pc;
		endcase
	end

	// PC and stack pointer, sp saturates at both ends
	always_ff @(posedge cpu_clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= PROG_START;
			sp <= '0;
		end else begin
			if (pc_src != PC_HOLD)
				pc <= pc_d;
			if (stack_op == STACK_PUSH && !full)
				sp <= sp + 1'b1;
			else if (stack_op == STACK_POP && !empty)
				sp <= sp - 1'b1;
		end
	end

	// Return address is the word after the CALL
	always_ff @(posedge cpu_clk) begin
		if (stack_op == STACK_PUSH && !full)
			stack_mem[IDX_W'(sp)] <= pc + 12'd2;
	end

endmodule

// File: hw/chip8_sequencer.sv
// Instruction sequencer of the CHIP-8 core: fetch handshake, decode, write-back and Fx55 stores
`timescale 1ns/1ns

module chip8_sequencer
	import chip8_isa_pkg::*;
	import chip8_ctrl_pkg::*;
(
	input  logic        cpu_clk,
	input  logic        rst_n,
	input  instr_t      instr,
	input  logic        instr_valid,
	output logic        instr_ready,
	input  logic        mem_ready,
	output logic        mem_valid,
	output addr_t       mem_addr,
	output byte_t       mem_data,
	input  addr_t       pc,
	input  byte_t       alu_result,
	input  logic        alu_flag,
	chip8_reg_if.sequencer regs,
	output pc_src_e     pc_src,
	output addr_t       jump_addr,
	output stack_op_e   stack_op,
	output byte_t       alu_a,
	output byte_t       alu_b,
	output alu_op_e     alu_op
);

	seq_state_e state, state_d;
	logic       ready_q;
	instr_t     instr_q;
	reg_idx_t   store_cnt;
	byte_t      vx_q, vy_q;

	// Instruction fields
	logic [3:0] opcode, sub_op;
	reg_idx_t   x_idx, y_idx;
	byte_t      kk;
	addr_t      nnn;
	logic       accept, is_store, last_store;

	assign opcode = instr_q[15:12];
	assign x_idx  = instr_q[11:8];
	assign y_idx  = instr_q[7:4];
	assign sub_op = instr_q[3:0];
	assign kk     = instr_q[7:0];
	assign nnn    = instr_q[11:0];

	assign instr_ready = ready_q;
	assign accept      = ready_q && instr_valid;
	assign is_store    = (opcode == 4'hF) && (kk == 8'h55);
	assign last_store  = (store_cnt == x_idx);

	// Bnnn reads V0 instead of Vx, the store loop walks V0..Vx
	always_comb begin
		if (state == SEQ_STORE)
			regs.rd_idx1 = store_cnt;
		else if (opcode == 4'hB)
			regs.rd_idx1 = 4'h0;
		else
			regs.rd_idx1 = x_idx;
		regs.rd_idx2 = y_idx;
	end

	// Store port, one byte per counter step at I onward
	assign mem_valid = (state == SEQ_STORE);
	assign mem_addr  = regs.i_data + addr_t'(store_cnt);
	assign mem_data  = regs.rd_data1;

	always_comb begin
		state_d = state;
		case (state)
			SEQ_FETCH: if (accept) state_d = SEQ_READ;
			SEQ_READ:  state_d = is_store ? SEQ_STORE : SEQ_EXEC;
			SEQ_EXEC:  state_d = SEQ_FETCH;
			SEQ_STORE: if (mem_ready && last_store) state_d = SEQ_FETCH;
			default:   state_d = SEQ_FETCH;
		endcase
	end

	// Datapath steering, only active in exec and at the end of a store run
	always_comb begin
		pc_src        = PC_HOLD;
		stack_op      = STACK_HOLD;
		// Jump bus idles at the current PC
		jump_addr     = pc;
		alu_a         = vx_q;
		alu_b         = vy_q;
		alu_op        = ALU_PASS;
		regs.wr_en1   = 1'b0;
		regs.wr_idx1  = x_idx;
		regs.wr_data1 = alu_result;
		regs.wr_en2   = 1'b0;
		regs.wr_idx2  = FLAG_REG;
		regs.wr_data2 = {7'b0, alu_flag};
		regs.i_we     = 1'b0;
		regs.i_wdata  = nnn;

		if (state == SEQ_STORE && mem_ready && last_store)
			pc_src = PC_NEXT;

		if (state == SEQ_EXEC) begin
			// Unknown encodings fall through as a plain PC+2
			pc_src = PC_NEXT;
			case (opcode)
				4'h0: begin
					if (instr_q == 16'h00EE) begin
						pc_src   = PC_RETURN;
						stack_op = STACK_POP;
					end
				end
				4'h1: begin
					pc_src    = PC_JUMP;
					jump_addr = nnn;
				end
				4'h2: begin
					// Return address is pushed by the PC block
					pc_src    = PC_JUMP;
					jump_addr = nnn;
					stack_op  = STACK_PUSH;
				end
				4'h3: if (vx_q == kk) pc_src = PC_SKIP;
				4'h4: if (vx_q != kk) pc_src = PC_SKIP;
				4'h5: if (sub_op == 4'h0 && vx_q == vy_q) pc_src = PC_SKIP;
				4'h6: begin
					alu_b       = kk;
					alu_op      = ALU_PASS;
					regs.wr_en1 = 1'b1;
				end
				4'h7: begin
					// No flag for the immediate add
					alu_b       = kk;
					alu_op      = ALU_ADD;
					regs.wr_en1 = 1'b1;
				end
				4'h8: begin
					regs.wr_en1 = 1'b1;
					regs.wr_en2 = 1'b1;
					case (sub_op)
						4'h0: begin
							alu_op      = ALU_PASS;
							regs.wr_en2 = 1'b0;
						end
						4'h1: begin
							alu_op      = ALU_OR;
							regs.wr_en2 = 1'b0;
						end
						4'h2: begin
							alu_op      = ALU_AND;
							regs.wr_en2 = 1'b0;
						end
						4'h3: begin
							alu_op      = ALU_XOR;
							regs.wr_en2 = 1'b0;
						end
						4'h4: alu_op = ALU_ADD;
						4'h5: alu_op = ALU_SUB;
						4'h6: alu_op = ALU_SHR;
						4'h7: alu_op = ALU_SUBN;
						4'hE: alu_op = ALU_SHL;
						default: begin
							regs.wr_en1 = 1'b0;
							regs.wr_en2 = 1'b0;
						end
					endcase
				end
				4'h9: if (sub_op == 4'h0 && vx_q != vy_q) pc_src = PC_SKIP;
				4'hA: regs.i_we = 1'b1;
				4'hB: begin
					// vx_q holds V0 here
					pc_src    = PC_JUMP;
					jump_addr = nnn + addr_t'(vx_q);
				end
				4'hF: begin
					if (kk == 8'h1E) begin
						regs.i_we    = 1'b1;
						regs.i_wdata = regs.i_data + addr_t'(vx_q);
					end else if (kk == 8'h29) begin
						// Font glyphs start at address 0
						regs.i_we    = 1'b1;
						regs.i_wdata = addr_t'(vx_q) * FONT_STRIDE;
					end
				end
				default: ;
			endcase
		end
	end

	// Control registers
	always_ff @(posedge cpu_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= SEQ_FETCH;
			ready_q   <= 1'b0;
			instr_q   <= '0;
			store_cnt <= '0;
		end else begin
			state   <= state_d;
			// Ready comes up one edge after reset, then tracks the fetch state
			ready_q <= (state_d == SEQ_FETCH);
			if (accept)
				instr_q <= instr;
			if (state == SEQ_READ)
				store_cnt <= '0;
			else if (state == SEQ_STORE && mem_ready && !last_store)
				store_cnt <= store_cnt + 4'd1;
		end
	end

	// Operand latch, taken in the read cycle
	always_ff @(posedge cpu_clk) begin
		if (state == SEQ_READ) begin
			vx_q <= regs.rd_data1;
			vy_q <= regs.rd_data2;
		end
	end

endmodule

// File: hw/chip8_core.sv
// CHIP-8 execution core top level with fetch and store valid/ready ports
`timescale 1ns/1ns

module chip8_core
	import chip8_isa_pkg::*;
	import chip8_ctrl_pkg::*;
#(
	parameter int STACK_DEPTH = 16
) (
	input  logic   cpu_clk,
	input  logic   rst_n,
	// Fetch port
	input  instr_t instr,
	input  logic   instr_valid,
	output logic   instr_ready,
	output addr_t  fetch_addr,
	// Store port
	input  logic   mem_ready,
	output logic   mem_valid,
	output addr_t  mem_addr,
	output byte_t  mem_data
);

	addr_t     pc;
	addr_t     jump_addr;
	pc_src_e   pc_src;
	stack_op_e stack_op;
	byte_t     alu_a, alu_b, alu_result;
	alu_op_e   alu_op;
	logic      alu_flag;

	chip8_reg_if regs_if ();

	// Fetch address is the architectural PC
	assign fetch_addr = pc;

	chip8_sequencer u_seq (
		.cpu_clk     (cpu_clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.mem_ready   (mem_ready),
		.mem_valid   (mem_valid),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.pc          (pc),
		.alu_result  (alu_result),
		.alu_flag    (alu_flag),
		.regs        (regs_if),
		.pc_src      (pc_src),
		.jump_addr   (jump_addr),
		.stack_op    (stack_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_op      (alu_op)
	);

	chip8_regfile u_regfile (
		.cpu_clk (cpu_clk),
		.rst_n   (rst_n),
		.regs    (regs_if)
	);

	chip8_alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result),
		.flag   (alu_flag)
	);

	chip8_pc_stack #(
		.STACK_DEPTH (STACK_DEPTH)
	) u_pc_stack (
		.cpu_clk   (cpu_clk),
		.rst_n     (rst_n),
		.pc_src    (pc_src),
		.jump_addr (jump_addr),
		.stack_op  (stack_op),
		.pc        (pc)
	);

endmodule

// File: sim/chip8_core_properties.sv
// Handshake and return stack assertions, bound into every chip8_core instance
`timescale 1ns/1ns

module chip8_core_properties
	import chip8_isa_pkg::*;
	import chip8_ctrl_pkg::*;
#(
	parameter int STACK_DEPTH = 16
) (
	input logic      cpu_clk,
	input logic      rst_n,
	input logic      instr_ready,
	input logic      instr_valid,
	input addr_t     fetch_addr,
	input logic      mem_valid,
	input logic      mem_ready,
	input addr_t     mem_addr,
	input byte_t     mem_data,
	input stack_op_e stack_op
);

	int depth;

	// Shadow fill level of the return stack
	always_ff @(posedge cpu_clk or negedge rst_n) begin
		if (!rst_n)
			depth <= 0;
		else if (stack_op == STACK_PUSH && depth < STACK_DEPTH)
			depth <= depth + 1;
		else if (stack_op == STACK_POP && depth > 0)
			depth <= depth - 1;
	end

	// Fetch request holds until the handshake
	fetch_hold: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		instr_ready && !instr_valid |=> instr_ready && $stable(fetch_addr))
		else $error("fetch request changed before the handshake");

	// Store request holds until memory takes it
	store_hold: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_data))
		else $error("store request changed before mem_ready");

	reset_quiet: assert property (@(posedge cpu_clk) !rst_n |-> !mem_valid)
		else $error("mem_valid high during reset");

	push_room: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		stack_op == STACK_PUSH |-> depth < STACK_DEPTH)
		else $error("push on a full return stack");

	pop_data: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		stack_op == STACK_POP |-> depth > 0)
		else $error("pop on an empty return stack");

endmodule

bind chip8_core chip8_core_properties #(
	.STACK_DEPTH (STACK_DEPTH)
) props (
	.cpu_clk     (cpu_clk),
	.rst_n       (rst_n),
	.instr_ready (instr_ready),
	.instr_valid (instr_valid),
	.fetch_addr  (fetch_addr),
	.mem_valid   (mem_valid),
	.mem_ready   (mem_ready),
	.mem_addr    (mem_addr),
	.mem_data    (mem_data),
	.stack_op    (stack_op)
);

// File: sim/chip8_core_tb.sv
// Testbench that runs the CHIP-8 core instruction table with and without back-pressure
`timescale 1ns/1ns

module chip8_core_tb
	import chip8_isa_pkg::*;
();

	localparam int NUM_PASSES = 2;
	localparam int CYCLES_PER_ROW = 200;
	localparam int BP_FACTOR = 4;

	// DUT inputs start at known values
	logic   clk = 1'b0;
	logic   rst_n = 1'b0;
	instr_t instr = '0;
	logic   instr_valid = 1'b0;
	logic   mem_ready = 1'b0;

	// DUT outputs
	logic   instr_ready;
	addr_t  fetch_addr;
	logic   mem_valid;
	addr_t  mem_addr;
	byte_t  mem_data;

	// Run control
	logic        running = 1'b0;
	logic        bp_en = 1'b0;
	logic        table_ready = 1'b0;
	logic [15:0] lfsr = 16'd7;
	int          watchdog_cycles;
	int          n_stores;
	int          ready_wait = 0;
	string       cur_row = "";

	// Program ROM, data sink and transfer logs
	instr_t rom [addr_t];
	byte_t  dmem [addr_t];
	addr_t  fetch_log [$];
	addr_t  store_log [$];

	// Test table with one entry per row in each queue
	string        row_name [$];
	logic [127:0] row_prog [$];
	byte_t        row_v0 [$];
	byte_t        row_vf [$];
	addr_t        row_store [$];
	addr_t        row_land [$];

	chip8_core #(
		.STACK_DEPTH (16)
	) dut (
		.cpu_clk     (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.fetch_addr  (fetch_addr),
		.mem_ready   (mem_ready),
		.mem_valid   (mem_valid),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// Unloaded addresses read as a jump to themselves
	function automatic instr_t rom_word(input addr_t a);
		if (rom.exists(a))
			return rom[a];
		return {4'h1, a};
	endfunction

	// Index in the fetch log of the first JP, CALL, JP V0 or RET
	function automatic int transfer_index();
		instr_t w;
		for (int k = 0; k < fetch_log.size(); k++) begin
			w = rom_word(fetch_log[k]);
			if (w[15:12] inside {4'h1, 4'h2, 4'hB} || w == 16'h00EE)
				return k;
		end
		return -1;
	endfunction

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "byte check failed");
		end
	endtask

	task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "address check failed");
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %b actual %b", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "handshake check failed");
		end
	endtask

	task automatic add_row(input string name, input logic [127:0] prog, input byte_t v0,
			input byte_t vf, input addr_t first_store, input addr_t land);
		row_name.push_back(name);
		row_prog.push_back(prog);
		row_v0.push_back(v0);
		row_vf.push_back(vf);
		row_store.push_back(first_store);
		row_land.push_back(land);
	endtask

	// Drive on the rising edge and log what transferred before it
	always @(posedge clk) begin : drive_and_monitor
		logic fetch_ok;
		logic mem_ok;
		fetch_ok = 1'b1;
		mem_ok = 1'b1;
		if (!rst_n) begin
			instr_valid <= 1'b0;
			mem_ready <= 1'b0;
			fetch_log.delete();
			store_log.delete();
			dmem.delete();
			n_stores = 0;
			ready_wait = 0;
		end else begin
			// Read and exec take one cycle each, ready is back on the third edge
			if (ready_wait > 0) begin
				ready_wait--;
				check_bit({cur_row, " instr_ready"}, ready_wait == 0, instr_ready);
			end
			if (instr_ready && instr_valid) begin
				fetch_log.push_back(fetch_addr);
				// Store runs have a variable length
				if (instr[15:12] == 4'hF && instr[7:0] == 8'h55)
					ready_wait = 0;
				else
					ready_wait = 3;
			end
			if (mem_valid && mem_ready) begin
				dmem[mem_addr] = mem_data;
				store_log.push_back(mem_addr);
				n_stores++;
			end
			// One LFSR step per stall bit
			if (bp_en) begin
				lfsr = lfsr_next(lfsr);
				fetch_ok = lfsr[0];
				lfsr = lfsr_next(lfsr);
				mem_ok = lfsr[0];
			end
			// PC only moves while ready is low, so the word matches fetch_addr
			instr <= rom_word(fetch_addr);
			instr_valid <= running && instr_ready && !instr_valid && fetch_ok;
			mem_ready <= running && mem_ok;
		end
	end

	// Load one row and reset, then run to the last store and check
	task automatic run_row(input int r);
		instr_t w;
		int     exp_stores;
		int     k;
		string  name;
		name = row_name[r];
		cur_row = name;
		rom.delete();
		// The final A300 and FF55 always store sixteen bytes
		exp_stores = 16;
		for (int i = 0; i < 8; i++) begin
			w = row_prog[r][127 - 16 * i -: 16];
			rom[PROG_START + addr_t'(2 * i)] = w;
			if (w == 16'hFF55)
				exp_stores += 16;
		end
		rom[PROG_START + 12'h010] = 16'hA300;
		rom[PROG_START + 12'h012] = 16'hFF55;
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		running <= 1'b1;
		wait (n_stores == exp_stores);
		running <= 1'b0;
		@(posedge clk);
		check_addr({name, " first fetch"}, PROG_START, fetch_log[0]);
		if (row_land[r] != '0) begin
			k = transfer_index();
			if (k < 0 || k + 1 >= fetch_log.size()) begin
				$display("%s: no instruction was fetched after a control transfer", name);
				$display("TB FAILED");
				$fatal(1, "missing control transfer");
			end else begin
				check_addr({name, " landing"}, row_land[r], fetch_log[k + 1]);
			end
		end
		check_addr({name, " first store"}, row_store[r], store_log[0]);
		check_byte({name, " V0"}, row_v0[r], dmem[12'h300]);
		check_byte({name, " VF"}, row_vf[r], dmem[12'h30F]);
	endtask

	initial begin
		// Loads and arithmetic
		add_row("add_imm", {16'h6F55, 16'h60FF, 16'h7002, 80'h0}, 8'h01, 8'h55, 12'h300, 12'h0);
		add_row("add_nc", {16'h6010, 16'h6120, 16'h8014, 80'h0}, 8'h30, 8'h00, 12'h300, 12'h0);
		add_row("add_c", {16'h60F0, 16'h6120, 16'h8014, 80'h0}, 8'h10, 8'h01, 12'h300, 12'h0);
		add_row("sub_nb", {16'h6050, 16'h6120, 16'h8015, 80'h0}, 8'h30, 8'h01, 12'h300, 12'h0);
		add_row("sub_eq", {16'h6020, 16'h6120, 16'h8015, 80'h0}, 8'h00, 8'h01, 12'h300, 12'h0);
		add_row("sub_b", {16'h6010, 16'h6120, 16'h8015, 80'h0}, 8'hF0, 8'h00, 12'h300, 12'h0);
		add_row("subn_nb", {16'h6010, 16'h6130, 16'h8017, 80'h0}, 8'h20, 8'h01, 12'h300, 12'h0);
		add_row("subn_b", {16'h6040, 16'h6130, 16'h8017, 80'h0}, 8'hF0, 8'h00, 12'h300, 12'h0);
		// Logic and shifts
		add_row("ld_reg", {16'h6133, 16'h8010, 96'h0}, 8'h33, 8'h00, 12'h300, 12'h0);
		add_row("or", {16'h6055, 16'h61A0, 16'h8011, 80'h0}, 8'hF5, 8'h00, 12'h300, 12'h0);
		add_row("and", {16'h6055, 16'h61F0, 16'h8012, 80'h0}, 8'h50, 8'h00, 12'h300, 12'h0);
		add_row("xor", {16'h6055, 16'h61FF, 16'h8013, 80'h0}, 8'hAA, 8'h00, 12'h300, 12'h0);
		add_row("shr", {16'h6003, 16'h8006, 96'h0}, 8'h01, 8'h01, 12'h300, 12'h0);
		add_row("shl", {16'h6081, 16'h800E, 96'h0}, 8'h02, 8'h01, 12'h300, 12'h0);
		// Skips where the slot after each skip loads 0x99
		add_row("se_hit", {16'h6042, 16'h3042, 16'h6099, 80'h0}, 8'h42, 8'h00, 12'h300, 12'h0);
		add_row("se_miss", {16'h6042, 16'h3043, 16'h6099, 80'h0}, 8'h99, 8'h00, 12'h300, 12'h0);
		add_row("sne_hit", {16'h6042, 16'h4043, 16'h6099, 80'h0}, 8'h42, 8'h00, 12'h300, 12'h0);
		add_row("sne_miss", {16'h6042, 16'h4042, 16'h6099, 80'h0}, 8'h99, 8'h00, 12'h300, 12'h0);
		add_row("sexy_hit", {16'h6042, 16'h6142, 16'h5010, 16'h6099, 64'h0},
			8'h42, 8'h00, 12'h300, 12'h0);
		add_row("sexy_miss", {16'h6042, 16'h6143, 16'h5010, 16'h6099, 64'h0},
			8'h99, 8'h00, 12'h300, 12'h0);
		add_row("snexy_hit", {16'h6042, 16'h6143, 16'h9010, 16'h6099, 64'h0},
			8'h42, 8'h00, 12'h300, 12'h0);
		add_row("snexy_miss", {16'h6042, 16'h6142, 16'h9010, 16'h6099, 64'h0},
			8'h99, 8'h00, 12'h300, 12'h0);
		// Jumps with the landing address of the first transfer in the last column
		// Targets lie past PC+4 so a skip lands elsewhere
		add_row("jp", {16'h6011, 16'h1208, 16'h6022, 16'h7001, 16'h7002, 48'h0},
			8'h13, 8'h00, 12'h300, 12'h208);
		add_row("jp_v0", {16'h6006, 16'hB202, 16'h6022, 16'h7001, 16'h7002, 48'h0},
			8'h08, 8'h00, 12'h300, 12'h208);
		// CALL 20A, add 2, RET to 204, add 10, JP over the gap
		add_row("call_ret", {16'h6001, 16'h220A, 16'h7010, 16'h120E,
			16'h0000, 16'h7002, 16'h00EE, 16'h0000}, 8'h13, 8'h00, 12'h300, 12'h20A);
		// Index register rows where the first store lands at the new I
		add_row("ld_i", {16'h6007, 16'hA123, 16'hFF55, 80'h0}, 8'h07, 8'h00, 12'h123, 12'h0);
		add_row("add_i", {16'h6010, 16'hA100, 16'hF01E, 16'hFF55, 64'h0},
			8'h10, 8'h00, 12'h100 + 12'h010, 12'h0);
		add_row("ld_f", {16'h600B, 16'hF029, 16'hFF55, 80'h0},
			8'h0B, 8'h00, 12'h00B * FONT_STRIDE, 12'h0);
		watchdog_cycles = row_name.size() * NUM_PASSES * CYCLES_PER_ROW * BP_FACTOR;
		table_ready = 1'b1;
		// Second pass repeats the table under random stalls
		for (int pass = 0; pass < NUM_PASSES; pass++) begin
			bp_en <= (pass == 1);
			for (int r = 0; r < row_name.size(); r++)
				run_row(r);
		end
		$display("TB PASSED");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		wait (table_ready);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Run stalled, no completion within %0d cycles", watchdog_cycles);
		$display("TB FAILED");
		$fatal(1, "watchdog timeout");
	end

endmodule

// File: chip8_core.f
hw/chip8_isa_pkg.sv
hw/chip8_ctrl_pkg.sv
hw/chip8_reg_if.sv
hw/chip8_alu.sv
hw/chip8_regfile.sv
hw/chip8_pc_stack.sv
hw/chip8_sequencer.sv
hw/chip8_core.sv
sim/chip8_core_properties.sv
sim/chip8_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
TOP       := chip8_core_tb
FILELIST  := chip8_core.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
